// File: common/trs_io_pkg.sv
package trs_io_pkg;

  // spi command opcodes sent by the esp, anything else is ignored
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    dbus_read        = 8'd3,
    dbus_write       = 8'd4,   // one parameter byte follows
    data_ready       = 8'd5,
    get_version      = 8'd15,
    get_printer_byte = 8'd16
  } esp_cmd_e;

  // code on esp_s telling the esp what kind of bus access is waiting
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    esp_none   = 4'd15   // nothing selected
  } esp_status_e;

  // spi command fsm
  typedef enum logic [1:0] {
    idle        = 2'd0,
    read_params = 2'd1
  } cmd_state_e;

  // bus addresses
  localparam logic [7:0]  TRS_IO_PORT   = 8'd31;
  localparam logic [3:0]  FREHD_PORT_HI = 4'hc;     // ports 0xc0..0xcf
  localparam logic [15:0] PRINTER_ADDR  = 16'h37e8;

  // printer status as read back by the host
  localparam logic [7:0] PRINTER_READY = 8'h30;
  localparam logic [7:0] PRINTER_BUSY  = 8'hf0;

  // fixed replies
  localparam logic [7:0] COOKIE        = 8'haf;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;     // reply byte is {major, minor}

endpackage

// File: spi_link/spi_byte_port.sv
`timescale 1ns/1ps

module spi_byte_port (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  input  logic       rx_enable,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  input  logic       tx_load,
  input  logic [7:0] tx_byte,
  output logic       tx_busy
);

  logic [2:0] sck_sync;    // [0] metastability stage, [2:1] edge detect
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;   // two stages so mosi lines up with sck_sync[1]
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic       cs_rise;     // end of frame
  logic [2:0] bit_cnt;
  logic       byte_done;
  logic [7:0] tx_shift;    // bits still to go, msb next
  logic [3:0] tx_cnt;      // remaining reply bits
  logic       tx_armed;    // set once the master clocks the reply byte

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;   // deselected
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];
  assign cs_rise   = (cs_sync[2:1] == 2'b01);

  // receive side, mode 0 so mosi is sampled on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt   <= 3'd0;
      byte_done <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      byte_done <= cs_active && sck_rise && (bit_cnt == 3'd7);
      rx_valid  <= byte_done && rx_enable;   // reply bits never reach the fsm
      if (!cs_active)
        bit_cnt <= 3'd0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
  end

  // transmit side, msb goes out at load, the rest on falling sck
  always_ff @(posedge clk) begin
    if (rst || cs_rise) begin
      tx_cnt   <= 4'd0;
      tx_armed <= 1'b0;
      miso     <= 1'b0;
    end else if (tx_load) begin
      tx_cnt   <= 4'd8;
      tx_armed <= 1'b0;   // ignore the tail of the command byte
      miso     <= tx_byte[7];
    end else if (tx_busy) begin
      if (sck_rise)
        tx_armed <= 1'b1;
      if (sck_fall && tx_armed) begin
        miso   <= tx_shift[7];
        tx_cnt <= tx_cnt - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load)
      tx_shift <= {tx_byte[6:0], 1'b0};
    else if (tx_busy && tx_armed && sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};   // zeros follow, miso idles low
  end

  assign tx_busy = (tx_cnt != 4'd0);

  // the command fsm must wait until the previous reply has left
  a_load_idle: assert property (@(posedge clk) disable iff (rst) tx_load |-> !tx_busy);

endmodule

// File: spi_link/esp_cmd_decoder.sv
`timescale 1ns/1ps

module esp_cmd_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx_valid,
  input  logic [7:0]           rx_byte,
  output logic                 rx_enable,
  output logic                 tx_load,
  output logic [7:0]           tx_byte,
  input  logic                 tx_busy,
  output logic                 action,
  output trs_io_pkg::esp_cmd_e action_cmd,
  output logic [7:0]           param0,
  input  logic [7:0]           bus_data,
  input  logic [7:0]           printer_byte
);

  import trs_io_pkg::*;

  cmd_state_e state;
  esp_cmd_e   cmd_in;       // incoming byte seen as opcode
  logic       cmd_known;
  logic       cmd_reply;    // opcode answers with one byte
  logic [7:0] reply_byte;

  assign cmd_in = esp_cmd_e'(rx_byte);

  // no new command bytes while a reply is being clocked out
  assign rx_enable = ~tx_busy;

  // opcode lookup
  always_comb begin
    cmd_known  = 1'b1;
    cmd_reply  = 1'b1;
    reply_byte = 8'h00;
    case (cmd_in)
      get_cookie:       reply_byte = COOKIE;
      get_version:      reply_byte = {VERSION_MAJOR, VERSION_MINOR};
      get_printer_byte: reply_byte = printer_byte;
      dbus_read:        reply_byte = bus_data;   // whatever the host drives now
      dbus_write,
      data_ready:       cmd_reply  = 1'b0;       // no answer
      default: begin
        cmd_known = 1'b0;   // unknown opcode, dropped
        cmd_reply = 1'b0;
      end
    endcase
  end

  // command fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= idle;
      action     <= 1'b0;
      tx_load    <= 1'b0;
      action_cmd <= get_cookie;
    end else begin
      action  <= 1'b0;   // single cycle strobes
      tx_load <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            if (cmd_in == dbus_write) begin
              state <= read_params;   // wait for the data byte
            end else if (cmd_known) begin
              action     <= 1'b1;
              action_cmd <= cmd_in;
              tx_load    <= cmd_reply;
            end
          end
          read_params: begin
            // only dbus_write takes a parameter
            action     <= 1'b1;
            action_cmd <= dbus_write;
            state      <= idle;
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  // reply byte and parameter capture
  always_ff @(posedge clk) begin
    if (rx_valid && state == idle)
      tx_byte <= reply_byte;   // bus data sampled together with the action
    if (rx_valid && state == read_params)
      param0 <= rx_byte;
  end

endmodule

// File: verilog/trs_bus_decoder.sv
`timescale 1ns/1ps

module trs_bus_decoder #(
  parameter int REQ_PULSE_CYCLES  = 50,
  parameter int STROBE_FILTER_LEN = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [15:0]             a,
  input  logic [7:0]              d_in,
  output logic [7:0]              d_out,
  output logic                    d_oe,
  input  logic                    rd_n,
  input  logic                    wr_n,
  input  logic                    in_n,
  input  logic                    out_n,
  output logic                    req,
  input  logic                    done,
  output trs_io_pkg::esp_status_e esp_s,
  output logic                    wait_req,
  output logic                    irq,
  input  logic                    action,
  input  trs_io_pkg::esp_cmd_e    action_cmd,
  input  logic [7:0]              param0,
  output logic [7:0]              printer_byte
);

  import trs_io_pkg::*;

  localparam int FLT_W = $clog2(STROBE_FILTER_LEN + 1);
  localparam int CNT_W = $clog2(REQ_PULSE_CYCLES + 1);

  logic             strobe_raw;
  logic [FLT_W-1:0] flt_cnt;      // consecutive low samples
  logic             strobe_ok;
  logic             strobe_ok_q;
  logic             access;       // one pulse per bus access
  logic             io31, frehd_port, prn_addr;
  logic             trs_io_sel_in, trs_io_sel_out;
  logic             frehd_sel_in, frehd_sel_out;
  logic             prn_sel_wr, prn_sel_rd;
  logic             esp_sel;
  logic             esp_start;
  logic             start_prn, start_io31;
  logic [CNT_W-1:0] req_cnt;
  logic             prn_pending;  // printer byte not yet taken by the esp
  logic [1:0]       done_sync;
  logic             done_q, done_rise;

  // address decode
  assign io31       = (a[7:0] == TRS_IO_PORT);
  assign frehd_port = (a[7:4] == FREHD_PORT_HI);
  assign prn_addr   = (a == PRINTER_ADDR);

  assign trs_io_sel_in  = io31 && !in_n;
  assign trs_io_sel_out = io31 && !out_n;
  assign frehd_sel_in   = frehd_port && !in_n;
  assign frehd_sel_out  = frehd_port && !out_n;
  assign prn_sel_wr     = prn_addr && !wr_n;
  assign prn_sel_rd     = prn_addr && !rd_n;
  assign esp_sel = trs_io_sel_in || trs_io_sel_out || frehd_sel_in || frehd_sel_out ||
                   prn_sel_wr;

  // strobe filter, glitches shorter than STROBE_FILTER_LEN samples are dropped
  assign strobe_raw = !rd_n || !wr_n || !in_n || !out_n;
  assign strobe_ok  = (flt_cnt == FLT_W'(STROBE_FILTER_LEN));

  always_ff @(posedge clk) begin
    if (rst) begin
      flt_cnt     <= '0;
      strobe_ok_q <= 1'b0;
      access      <= 1'b0;
      esp_start   <= 1'b0;
    end else begin
      if (!strobe_raw)
        flt_cnt <= '0;
      else if (!strobe_ok)
        flt_cnt <= flt_cnt + FLT_W'(1);
      strobe_ok_q <= strobe_ok;
      access      <= strobe_ok && !strobe_ok_q;
      esp_start   <= access && esp_sel && !req && !wait_req;   // busy, ignore
    end
  end

  // what kind of service was asked for, and the printer byte
  always_ff @(posedge clk) begin
    start_prn  <= prn_sel_wr;
    start_io31 <= io31;
    if (access && prn_sel_wr && !req && !wait_req)
      printer_byte <= d_in;
  end

  // done handshake from the esp
  always_ff @(posedge clk) begin
    if (rst) begin
      done_sync <= 2'b00;
      done_q    <= 1'b0;
      done_rise <= 1'b0;
    end else begin
      done_sync <= {done_sync[0], done};
      done_q    <= done_sync[1];
      done_rise <= done_sync[1] && !done_q;
    end
  end

  // request pulse, wait and printer state
  always_ff @(posedge clk) begin
    if (rst) begin
      req         <= 1'b0;
      req_cnt     <= '0;
      wait_req    <= 1'b0;
      prn_pending <= 1'b0;
    end else begin
      if (req_cnt != '0)
        req_cnt <= req_cnt - CNT_W'(1);
      if (req_cnt == CNT_W'(1))
        req <= 1'b0;   // fixed length, done does not cut it short
      if (done_rise) begin
        wait_req    <= 1'b0;
        prn_pending <= 1'b0;
      end
      if (esp_start) begin
        req     <= 1'b1;
        req_cnt <= CNT_W'(REQ_PULSE_CYCLES);
        if (start_prn)
          prn_pending <= 1'b1;   // host never waits on the printer
        else
          wait_req <= 1'b1;
      end
    end
  end

  // data ready flag toward the host interrupt
  always_ff @(posedge clk) begin
    if (rst)
      irq <= 1'b0;
    else if (action && action_cmd == data_ready)
      irq <= 1'b1;
    else if (esp_start && start_io31)
      irq <= 1'b0;
  end

  // host read data
  always_ff @(posedge clk) begin
    if (action && action_cmd == dbus_write)
      d_out <= param0;
    else if (access && prn_sel_rd)
      d_out <= prn_pending ? PRINTER_BUSY : PRINTER_READY;
  end

  assign d_oe = (!in_n && (io31 || frehd_port)) || prn_sel_rd;

  always_comb begin
    if (trs_io_sel_in)       esp_s = trs_io_in;
    else if (trs_io_sel_out) esp_s = trs_io_out;
    else if (frehd_sel_in)   esp_s = frehd_in;
    else if (frehd_sel_out)  esp_s = frehd_out;
    else if (prn_pending)    esp_s = printer_wr;
    else                     esp_s = esp_none;
  end

  // esp may only report done for a service it was actually given
  a_done_has_service: assert property (@(posedge clk) disable iff (rst)
    (req && done_rise) |-> (wait_req || prn_pending));

endmodule

// File: verilog/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top #(
  parameter int REQ_PULSE_CYCLES  = 50,   // esp request length in clk
  parameter int STROBE_FILTER_LEN = 2     // samples a strobe must stay low
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  output logic [7:0]  d_out,
  output logic        d_oe,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        in_n,
  input  logic        out_n,
  output logic        req,
  input  logic        done,
  output logic [3:0]  esp_s,
  output logic        wait_req,
  output logic        irq,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso
);

  import trs_io_pkg::*;

  logic       rx_valid, rx_enable;
  logic [7:0] rx_byte;
  logic       tx_load, tx_busy;
  logic [7:0] tx_byte;
  logic       action;
  esp_cmd_e   action_cmd;
  logic [7:0] param0;
  logic [7:0] printer_byte;

  spi_byte_port i_spi_byte_port (
    .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .rx_enable(rx_enable), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .tx_load(tx_load), .tx_byte(tx_byte), .tx_busy(tx_busy)
  );

  // dbus_read replies with the live host data bus
  esp_cmd_decoder i_esp_cmd_decoder (
    .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte), .rx_enable(rx_enable),
    .tx_load(tx_load), .tx_byte(tx_byte), .tx_busy(tx_busy), .action(action),
    .action_cmd(action_cmd), .param0(param0), .bus_data(d_in), .printer_byte(printer_byte)
  );

  trs_bus_decoder #(
    .REQ_PULSE_CYCLES(REQ_PULSE_CYCLES),
    .STROBE_FILTER_LEN(STROBE_FILTER_LEN)
  ) i_trs_bus_decoder (
    .clk(clk), .rst(rst), .a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
    .rd_n(rd_n), .wr_n(wr_n), .in_n(in_n), .out_n(out_n), .req(req), .done(done),
    .esp_s(esp_s), .wait_req(wait_req), .irq(irq), .action(action),
    .action_cmd(action_cmd), .param0(param0), .printer_byte(printer_byte)
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  // reset spans the first rising edges, released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// File: test/tb_trs_io.sv
`timescale 1ns/1ps

module tb_trs_io;

  import trs_io_pkg::*;

  localparam int REQ_PULSE_CYCLES  = 50;
  localparam int STROBE_FILTER_LEN = 2;
  localparam int SPI_HALF          = 8;     // clk cycles per sck half period
  localparam int TMO               = 400;   // cycles before a wait gives up

  typedef enum logic [2:0] {
    spi_rd,     // command with one reply byte, d_in driven with data
    spi_cmd,    // command without reply, irq checked afterwards
    prn_wr,     // host write to the printer address
    io_out,     // host OUT served by the esp
    io_in,      // host IN served by the esp, data is the expected d_out
    bus_rd,     // plain host read, esp not involved
    esp_done,   // esp finishes the pending printer job
    quiet       // no traffic, d_out and irq checked
  } row_kind_e;

  logic        clk, rst;
  logic [15:0] a;
  logic [7:0]  d_in, d_out;
  logic        d_oe, rd_n, wr_n, in_n, out_n;
  logic        req, done, wait_req, irq;
  logic [3:0]  esp_s;
  logic        sck, cs_n, mosi, miso;

  // stimulus table, spi rows carry the opcode in addr[7:0]
  string       row_name[$];
  row_kind_e   row_kind[$];
  logic [15:0] row_addr[$];
  logic [7:0]  row_data[$];
  logic [7:0]  row_exp[$];

  string cur_name;
  int    errors;
  int    n_tests;
  int    n_bad;
  bit    timed_out;
  int    seed;

  tb_clk_gen i_tb_clk_gen (.clk(clk), .rst(rst));

  trs_io_top #(
    .REQ_PULSE_CYCLES(REQ_PULSE_CYCLES),
    .STROBE_FILTER_LEN(STROBE_FILTER_LEN)
  ) i_trs_io_top (
    .clk(clk), .rst(rst), .a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
    .rd_n(rd_n), .wr_n(wr_n), .in_n(in_n), .out_n(out_n), .req(req), .done(done),
    .esp_s(esp_s), .wait_req(wait_req), .irq(irq),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso)
  );

  task automatic add_row(input string name, input row_kind_e kind, input logic [15:0] addr,
                         input logic [7:0] data, input logic [7:0] exp);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(exp);
  endtask

  task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] got);
    assert (got == exp) else begin
      $display("[FAIL] %s %s expected 0x%0h actual 0x%0h", cur_name, what, exp, got);
      errors++;
    end
  endtask

  task automatic timeout_check(input int n, input string what);
    assert (n < TMO) else begin
      $display("error in %s: gave up waiting, %s", cur_name, what);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // mode 0, master samples miso as it raises sck
  task automatic spi_shift(input logic [7:0] tx, output logic [7:0] rx);
    rx = 8'h00;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (SPI_HALF) step();
      rx[i] = miso;
      sck = 1'b1;
      repeat (SPI_HALF) step();
      sck = 1'b0;
    end
  endtask

  task automatic spi_frame(input logic [7:0] op, input bit has_param, input logic [7:0] param,
                           input bit has_reply, output logic [7:0] reply);
    logic [7:0] unused_rx;
    reply = 8'h00;
    step();
    cs_n = 1'b0;
    repeat (SPI_HALF) step();
    spi_shift(op, unused_rx);
    if (has_param)
      spi_shift(param, unused_rx);
    if (has_reply)
      spi_shift(8'hff, reply);   // filler is an unknown opcode
    repeat (SPI_HALF) step();
    cs_n = 1'b1;
    repeat (SPI_HALF) step();   // let the port see the frame end
  endtask

  task automatic bus_start(input row_kind_e kind, input logic [15:0] addr,
                           input logic [7:0] data);
    step();
    a     = addr;
    d_in  = (kind == io_in) ? 8'h00 : data;   // keep expected read data off d_in
    rd_n  = !(kind == bus_rd);
    wr_n  = !(kind == prn_wr);
    in_n  = !(kind == io_in);
    out_n = !(kind == io_out);
  endtask

  task automatic bus_end();
    step();
    rd_n  = 1'b1;
    wr_n  = 1'b1;
    in_n  = 1'b1;
    out_n = 1'b1;
  endtask

  // printer status lands on d_out one cycle before a request would rise
  task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp);
    bus_start(bus_rd, addr, 8'h00);
    repeat (STROBE_FILTER_LEN + 4) @(negedge clk);
    check_val("d_oe", 16'd1, 16'(d_oe));
    check_val("d_out", 16'(exp), 16'(d_out));
    bus_end();
  endtask

  task automatic pulse_done();
    int delay;
    delay = $unsigned($random(seed)) % 8;   // esp service time
    repeat (delay) step();
    done = 1'b1;
    repeat (2) step();
    done = 1'b0;
  endtask

  task automatic esp_access(input row_kind_e kind, input logic [15:0] addr,
                            input logic [7:0] data, input logic [7:0] exp);
    int n;
    int len;
    bit saw_wait;
    bus_start(kind, addr, data);
    n = 0;
    while (req !== 1'b1 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    timeout_check(n, "req never rose");
    check_val("esp_s", 16'(exp[3:0]), 16'(esp_s));
    check_val("wait_req with req", (kind == prn_wr) ? 16'd0 : 16'd1, 16'(wait_req));
    len = 0;
    saw_wait = 1'b0;
    while (req === 1'b1 && len < TMO) begin   // count high cycles
      saw_wait = saw_wait | wait_req;
      len++;
      @(negedge clk);
    end
    check_val("req cycles", 16'(REQ_PULSE_CYCLES), 16'(len));
    if (kind == prn_wr) begin
      check_val("wait_req seen", 16'd0, 16'(saw_wait));   // printer never stalls host
    end else begin
      check_val("wait_req before done", 16'd1, 16'(wait_req));   // host still held
      pulse_done();
      n = 0;
      while (wait_req !== 1'b0 && n < TMO) begin
        @(negedge clk);
        n++;
      end
      timeout_check(n, "wait_req never fell after done");
      if (kind == io_in) begin
        check_val("d_oe", 16'd1, 16'(d_oe));
        check_val("d_out", 16'(data), 16'(d_out));
      end
    end
    bus_end();
  endtask

  task automatic run_row(input int i);
    int n;
    logic [7:0] reply;
    logic [15:0] addr;
    logic [7:0] data;
    logic [7:0] exp;
    addr = row_addr[i];
    data = row_data[i];
    exp  = row_exp[i];
    case (row_kind[i])
      spi_rd: begin
        step();
        d_in = data;   // live bus value for dbus_read
        spi_frame(addr[7:0], 1'b0, 8'h00, 1'b1, reply);
        check_val("reply", 16'(exp), 16'(reply));
      end
      spi_cmd: begin
        spi_frame(addr[7:0], addr[7:0] == 8'(dbus_write), data, 1'b0, reply);
        @(negedge clk);
        check_val("irq", 16'(exp[0]), 16'(irq));
      end
      prn_wr, io_out, io_in: esp_access(row_kind[i], addr, data, exp);
      bus_rd: bus_read(addr, exp);
      esp_done: begin
        pulse_done();
        n = 0;
        while (esp_s === 4'(printer_wr) && n < TMO) begin
          @(negedge clk);
          n++;
        end
        timeout_check(n, "printer job never cleared");
        check_val("esp_s", 16'(exp[3:0]), 16'(esp_s));
      end
      default: begin   // quiet
        @(negedge clk);
        check_val("req", 16'd0, 16'(req));
        check_val("irq", 16'(exp[0]), 16'(irq));
        check_val("d_out", 16'(data), 16'(d_out));
      end
    endcase
  endtask

  task automatic report_test(input int errs_before);
    n_tests++;
    if (errors == errs_before) begin
      $display("[ok]   %s", cur_name);
    end else begin
      $display("[bad]  %s", cur_name);
      n_bad++;
    end
  endtask

  initial begin
    int n;
    int errs_before;
    a = 16'h0000;
    d_in = 8'h00;
    rd_n = 1'b1;
    wr_n = 1'b1;
    in_n = 1'b1;
    out_n = 1'b1;
    done = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    seed = 32'hb30;
    errors = 0;
    n_tests = 0;
    n_bad = 0;
    timed_out = 1'b0;

    add_row("get_cookie",     spi_rd,   16'(get_cookie),       8'h00, 8'haf);
    add_row("get_version",    spi_rd,   16'(get_version),      8'h00, 8'h03);
    add_row("printer_write",  prn_wr,   16'h37e8,              8'h5a, 8'(printer_wr));
    add_row("printer_busy",   bus_rd,   16'h37e8,              8'h00, 8'hf0);
    add_row("printer_byte",   spi_rd,   16'(get_printer_byte), 8'h00, 8'h5a);
    add_row("printer_done",   esp_done, 16'h0000,              8'h00, 8'(esp_none));
    add_row("printer_ready",  bus_rd,   16'h37e8,              8'h00, 8'h30);
    add_row("out_trs_io",     io_out,   16'h001f,              8'h11, 8'(trs_io_out));
    add_row("in_frehd",       io_in,    16'h00c4,              8'h30, 8'(frehd_in));
    add_row("data_ready",     spi_cmd,  16'(data_ready),       8'h00, 8'h01);
    add_row("in_trs_io_irq",  io_in,    16'h001f,              8'h30, 8'(trs_io_in));
    add_row("irq_cleared",    quiet,    16'h0000,              8'h30, 8'h00);
    add_row("dbus_write",     spi_cmd,  16'(dbus_write),       8'ha5, 8'h00);
    add_row("in_trs_io_data", io_in,    16'h001f,              8'ha5, 8'(trs_io_in));
    add_row("dbus_read",      spi_rd,   16'(dbus_read),        8'h3c, 8'h3c);
    add_row("unknown_op",     spi_rd,   16'h007e,              8'h00, 8'h00);
    add_row("no_action",      quiet,    16'h0000,              8'ha5, 8'h00);
    add_row("cookie_again",   spi_rd,   16'(get_cookie),       8'h00, 8'haf);

    cur_name = "reset_state";
    errs_before = errors;
    n = 0;
    while (rst !== 1'b0 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    timeout_check(n, "reset never released");
    @(negedge clk);
    check_val("req", 16'd0, 16'(req));
    check_val("wait_req", 16'd0, 16'(wait_req));
    check_val("irq", 16'd0, 16'(irq));
    check_val("d_oe", 16'd0, 16'(d_oe));
    check_val("esp_s", 16'(esp_none), 16'(esp_s));
    check_val("miso", 16'd0, 16'(miso));
    report_test(errs_before);

    for (int i = 0; i < row_name.size() && !timed_out; i++) begin
      cur_name = row_name[i];
      errs_before = errors;
      run_row(i);
      report_test(errs_before);
    end

    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_bad, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/trs_io_pkg.sv
spi_link/spi_byte_port.sv
spi_link/esp_cmd_decoder.sv
verilog/trs_bus_decoder.sv
verilog/trs_io_top.sv
test/tb_clk_gen.sv
test/tb_trs_io.sv

// File: Makefile
TOP = tb_trs_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
